// File: design/lcd_vga_pkg.sv
// lcd vga package
// shared timing constants, lcd ram geometry and the pipeline structs
// for the panel mirror display: 800x600 at 60 Hz from a 40 MHz pixel clock
package lcd_vga_pkg;

    localparam int CNT_W = 11;                                   // column and line counters

    // horizontal timing, in pixel clocks
    localparam logic [CNT_W-1:0] H_VISIBLE    = 11'd800;
    localparam logic [CNT_W-1:0] H_SYNC_START = 11'd840;         // first column with hsync
    localparam logic [CNT_W-1:0] H_SYNC_END   = 11'd968;         // last column with hsync
    localparam logic [CNT_W-1:0] H_TOTAL      = 11'd1056;

    // vertical timing, in lines
    localparam logic [CNT_W-1:0] V_VISIBLE    = 11'd600;
    localparam logic [CNT_W-1:0] V_SYNC_START = 11'd600;
    localparam logic [CNT_W-1:0] V_SYNC_END   = 11'd603;
    localparam logic [CNT_W-1:0] V_TOTAL      = 11'd628;

    localparam int LCD_DEPTH = 128;                              // nibbles per bank
    localparam int LCD_AW    = 7;
    localparam int NIB_W     = 4;

    // lcd window at the top left of the picture
    localparam logic [CNT_W-1:0] LCD_LINES  = 11'd16;
    localparam logic [CNT_W-1:0] SLAVE1_END = 11'd192;           // first column past slave 1
    localparam logic [CNT_W-1:0] SLAVE2_END = 11'd384;
    localparam logic [CNT_W-1:0] MASTER_END = 11'd576;

    // bank field, write address bits 9:8
    localparam logic [1:0] BANK_NONE   = 2'd0;
    localparam logic [1:0] BANK_SLAVE1 = 2'd1;
    localparam logic [1:0] BANK_SLAVE2 = 2'd2;
    localparam logic [1:0] BANK_MASTER = 2'd3;

    typedef struct packed {
        logic [CNT_W-1:0] column;
        logic [CNT_W-1:0] line;
        logic             visible;
        logic             hsync;
        logic             vsync;
    } scan_pos_t;

    typedef struct packed {
        logic              we;                                   // single cycle strobe
        logic [1:0]        bank;
        logic [LCD_AW-1:0] index;
        logic [NIB_W-1:0]  data;
    } lcd_write_t;

    typedef struct packed {
        scan_pos_t        pos;
        logic [NIB_W-1:0] slave1;
        logic [NIB_W-1:0] slave2;
        logic [NIB_W-1:0] master;
    } fetch_out_t;

endpackage

// File: design/scan_timing.sv
// scan timing, pipeline stage 1
// horizontal and vertical counters for the 800x600 frame
// the visible, hsync and vsync levels are registered together with the
// position they belong to
`timescale 1ns/100ps

module scan_timing (
    input  logic                   clk_in,
    input  logic                   reset_in,
    output lcd_vga_pkg::scan_pos_t pos_o
);

    lcd_vga_pkg::scan_pos_t pos_q;
    logic [lcd_vga_pkg::CNT_W-1:0] col_nxt;
    logic [lcd_vga_pkg::CNT_W-1:0] line_nxt;
    logic col_wrap;
    logic line_wrap;

    assign col_wrap  = (pos_q.column == lcd_vga_pkg::H_TOTAL - 11'd1);
    assign line_wrap = (pos_q.line == lcd_vga_pkg::V_TOTAL - 11'd1);

    always_comb
    begin
        col_nxt  = pos_q.column + 11'd1;
        line_nxt = pos_q.line;
        if (col_wrap)
        begin
            col_nxt = '0;
            if (line_wrap)
                line_nxt = '0;                                   // end of frame
            else
                line_nxt = pos_q.line + 11'd1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            pos_q.column  <= '0;
            pos_q.line    <= '0;
            pos_q.visible <= 1'b1;                               // (0,0) is on screen
            pos_q.hsync   <= 1'b0;
            pos_q.vsync   <= 1'b0;
        end
        else
        begin
            pos_q.column  <= col_nxt;
            pos_q.line    <= line_nxt;
            pos_q.visible <= (col_nxt < lcd_vga_pkg::H_VISIBLE) &&
                             (line_nxt < lcd_vga_pkg::V_VISIBLE);
            pos_q.hsync   <= (col_nxt >= lcd_vga_pkg::H_SYNC_START) &&
                             (col_nxt <= lcd_vga_pkg::H_SYNC_END);   // positive pulse
            pos_q.vsync   <= (line_nxt >= lcd_vga_pkg::V_SYNC_START) &&
                             (line_nxt <= lcd_vga_pkg::V_SYNC_END);
        end
    end

    assign pos_o = pos_q;

    // counters stay inside the frame
    a_scan_in_frame: assert property (
        @(posedge clk_in) disable iff (reset_in)
        (pos_q.column < lcd_vga_pkg::H_TOTAL) && (pos_q.line < lcd_vga_pkg::V_TOTAL)
    );

endmodule

// File: design/lcd_bank.sv
// lcd bank
// one 128 nibble lcd controller ram image
// single write port and a registered read port so it maps to block ram
`timescale 1ns/100ps

module lcd_bank (
    input  logic                           clk_in,
    input  logic                           we_i,
    input  logic [lcd_vga_pkg::LCD_AW-1:0] waddr_i,
    input  logic [lcd_vga_pkg::NIB_W-1:0]  wdata_i,
    input  logic [lcd_vga_pkg::LCD_AW-1:0] raddr_i,
    output logic [lcd_vga_pkg::NIB_W-1:0]  rdata_o
);

    logic [lcd_vga_pkg::NIB_W-1:0] mem [0:lcd_vga_pkg::LCD_DEPTH-1];
    logic [lcd_vga_pkg::NIB_W-1:0] rdata_q;

    always_ff @(posedge clk_in)
    begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
    end

    // read returns the old nibble on a same cycle write
    always_ff @(posedge clk_in)
    begin
        rdata_q <= mem[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

// File: design/pixel_fetch.sv
// pixel fetch, pipeline stage 2
// decodes nibble writes into the slave 1, slave 2 and master banks and
// reads the nibble under the scanned position from all three
// the position is delayed one clock to stay aligned with the read data
`timescale 1ns/100ps

module pixel_fetch (
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  lcd_vga_pkg::lcd_write_t wr_i,
    input  lcd_vga_pkg::scan_pos_t  pos_i,
    output lcd_vga_pkg::fetch_out_t fetch_o
);

    logic [2:0] bank_we;                                         // master, slave2, slave1
    logic [lcd_vga_pkg::LCD_AW-1:0] rd_index;
    logic [lcd_vga_pkg::NIB_W-1:0] rd_slave1;
    logic [lcd_vga_pkg::NIB_W-1:0] rd_slave2;
    logic [lcd_vga_pkg::NIB_W-1:0] rd_master;
    lcd_vga_pkg::scan_pos_t pos_q;

    always_comb
    begin
        bank_we = 3'b000;
        if (wr_i.we)
        begin
            case (wr_i.bank)
                lcd_vga_pkg::BANK_NONE:   bank_we = 3'b000;      // ignored
                lcd_vga_pkg::BANK_SLAVE1: bank_we = 3'b001;
                lcd_vga_pkg::BANK_SLAVE2: bank_we = 3'b010;
                lcd_vga_pkg::BANK_MASTER: bank_we = 3'b100;
                default:                  bank_we = 3'b000;
            endcase
        end
    end

    // two nibble columns per byte, lines 8..15 use the odd entries
    assign rd_index = {pos_i.column[7:2], pos_i.line[3]};

    lcd_bank u_slave1 (
        .clk_in  (clk_in),
        .we_i    (bank_we[0]),
        .waddr_i (wr_i.index),
        .wdata_i (wr_i.data),
        .raddr_i (rd_index),
        .rdata_o (rd_slave1)
    );

    lcd_bank u_slave2 (
        .clk_in  (clk_in),
        .we_i    (bank_we[1]),
        .waddr_i (wr_i.index),
        .wdata_i (wr_i.data),
        .raddr_i (rd_index),
        .rdata_o (rd_slave2)
    );

    lcd_bank u_master (
        .clk_in  (clk_in),
        .we_i    (bank_we[2]),
        .waddr_i (wr_i.index),
        .wdata_i (wr_i.data),
        .raddr_i (rd_index),
        .rdata_o (rd_master)
    );

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
            pos_q <= '0;                                         // blank while filling
        else
            pos_q <= pos_i;
    end

    always_comb
    begin
        fetch_o.pos    = pos_q;
        fetch_o.slave1 = rd_slave1;
        fetch_o.slave2 = rd_slave2;
        fetch_o.master = rd_master;
    end

endmodule

// File: design/pixel_render.sv
// pixel render, pipeline stage 3
// picks the bank by column and the nibble bit by line inside the lcd
// window, draws a one pixel border elsewhere and blanks outside the
// visible area; sync and pixel leave this stage registered together
`timescale 1ns/100ps

module pixel_render (
    input  logic                    clk_in,
    input  logic                    reset_in,
    input  lcd_vga_pkg::fetch_out_t fetch_i,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    white_o
);

    logic [lcd_vga_pkg::CNT_W-1:0] col;
    logic [lcd_vga_pkg::CNT_W-1:0] line;
    logic [lcd_vga_pkg::NIB_W-1:0] nib;
    logic in_window;
    logic on_border;
    logic white_nxt;

    assign col  = fetch_i.pos.column;
    assign line = fetch_i.pos.line;

    assign in_window = (line < lcd_vga_pkg::LCD_LINES) && (col < lcd_vga_pkg::MASTER_END);
    assign on_border = (col == '0) || (col == lcd_vga_pkg::H_VISIBLE - 11'd1) ||
                       (line == '0) || (line == lcd_vga_pkg::V_VISIBLE - 11'd1);

    always_comb
    begin
        if (col < lcd_vga_pkg::SLAVE1_END)
            nib = fetch_i.slave1;                                // leftmost columns
        else if (col < lcd_vga_pkg::SLAVE2_END)
            nib = fetch_i.slave2;
        else
            nib = fetch_i.master;
    end

    always_comb
    begin
        white_nxt = 1'b0;                                        // blanking is black
        if (fetch_i.pos.visible)
        begin
            if (in_window)
                white_nxt = nib[line[2:1]];                      // two lines per bit
            else
                white_nxt = on_border;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            white_o <= 1'b0;
        end
        else
        begin
            hsync_o <= fetch_i.pos.hsync;
            vsync_o <= fetch_i.pos.vsync;
            white_o <= white_nxt;
        end
    end

    // no light outside the visible area
    a_white_visible: assert property (
        @(posedge clk_in) disable iff (reset_in)
        white_o |-> $past(fetch_i.pos.visible)
    );

endmodule

// File: design/lcd_vga_top.sv
// lcd vga top
// mirrors the three lcd controller rams onto an 800x600 vga picture
// three stage pipeline: scan timing, lcd ram fetch, pixel render
// outputs for a position appear two clocks after the scan holds it
`timescale 1ns/100ps

module lcd_vga_top (
    input  logic                          clk_in,
    input  logic                          reset_in,
    input  logic [9:0]                    addr_i,
    input  logic                          we_i,
    input  logic [lcd_vga_pkg::NIB_W-1:0] data_i,
    output logic                          hsync_o,
    output logic                          vsync_o,
    output logic                          white_o
);

    lcd_vga_pkg::lcd_write_t wr;
    lcd_vga_pkg::scan_pos_t  scan_pos;
    lcd_vga_pkg::fetch_out_t fetch;

    // addr bit 7 is not decoded, the controller ram only has 128 nibbles
    always_comb
    begin
        wr.we    = we_i;
        wr.bank  = addr_i[9:8];
        wr.index = addr_i[6:0];
        wr.data  = data_i;
    end

    scan_timing u_scan (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .pos_o    (scan_pos)
    );

    pixel_fetch u_fetch (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .wr_i     (wr),
        .pos_i    (scan_pos),
        .fetch_o  (fetch)
    );

    pixel_render u_render (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .fetch_i  (fetch),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .white_o  (white_o)
    );

endmodule

// File: tb/tb_clock.sv
// testbench clock and reset
// 100 ns clock, reset held high over the first five rising edges
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #50 clk_o = ~clk_o;
    end

    initial
    begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);                             // release away from the sampling edge
        reset_o = 1'b0;
    end

endmodule

// File: tb/lcd_vga_checker.sv
// lcd vga checker
// locks onto the scan at the first rising vsync edge, then predicts sync
// and pixel for every position from the frame rules and from a shadow of
// the three lcd rams kept from the write port
`timescale 1ns/100ps

module lcd_vga_checker (
    input logic       clk_in,
    input logic       reset_in,
    input logic [9:0] addr_i,
    input logic       we_i,
    input logic [3:0] data_i,
    input logic       hsync_i,
    input logic       vsync_i,
    input logic       white_i
);

    logic [3:0] shadow [0:2][0:127];
    logic       valid  [0:2][0:127];
    logic [1:0] rst_hist = 2'b00;                     // reset at the last two rising edges
    logic       locked   = 1'b0;
    logic       counting = 1'b0;
    logic       prev_vs  = 1'b0;
    int col            = 0;
    int line           = 0;
    int hs_cnt         = 0;
    int vs_cnt         = 0;
    int printed        = 0;
    int reset_errs     = 0;
    int reset_checks   = 0;
    int sync_errs      = 0;
    int border_errs    = 0;
    int window_errs    = 0;
    int window_checks  = 0;
    int frames_checked = 0;

    task automatic report_mismatch(input string sig, input int exp, input int got);
        begin
            if (printed < 20)
                $display("mismatch %s at column %0d line %0d: expected %h got %h",
                         sig, col, line, exp, got);
            printed++;
        end
    endtask

    // shadow rams, bank 0 writes go nowhere
    always @(posedge clk_in)
    begin
        rst_hist <= {rst_hist[0], reset_in};
        if (reset_in)
        begin
            for (int b = 0; b < 3; b++)
                for (int i = 0; i < 128; i++)
                    valid[b][i] <= 1'b0;
        end
        else if (we_i && addr_i[9:8] != 2'd0)
        begin
            shadow[addr_i[9:8] - 2'd1][addr_i[6:0]] <= data_i;
            valid[addr_i[9:8] - 2'd1][addr_i[6:0]]  <= 1'b1;
        end
    end

    always @(negedge clk_in)
    begin : compare
        logic exp_hs;
        logic exp_vs;
        logic exp_wh;
        int   b;
        int   idx;
        if (rst_hist != 2'b00)
        begin
            reset_checks++;
            if ({hsync_i, vsync_i, white_i} != 3'b000)
            begin
                reset_errs++;
                report_mismatch("hsync_o/vsync_o/white_o", 0,
                                int'({hsync_i, vsync_i, white_i}));
            end
        end
        else
        begin
            if (locked)
            begin
                col++;
                if (col == 1056)
                begin
                    col  = 0;
                    line = (line == 627) ? 0 : line + 1;
                end
            end
            else if (vsync_i && !prev_vs)
            begin
                locked = 1'b1;                        // vsync rises at column 0 of line 600
                col    = 0;
                line   = 600;
            end
            if (locked)
            begin
                if (col == 0 && line == 600)
                begin
                    if (counting)
                    begin
                        frames_checked++;
                        if (hs_cnt != 129 * 628)
                        begin
                            sync_errs++;
                            report_mismatch("hsync_o clocks per frame", 129 * 628, hs_cnt);
                        end
                        if (vs_cnt != 4 * 1056)
                        begin
                            sync_errs++;
                            report_mismatch("vsync_o clocks per frame", 4 * 1056, vs_cnt);
                        end
                    end
                    counting = 1'b1;
                    hs_cnt   = 0;
                    vs_cnt   = 0;
                end
                hs_cnt += int'(hsync_i);
                vs_cnt += int'(vsync_i);
                exp_hs = (col >= 840) && (col <= 968);
                exp_vs = (line >= 600) && (line <= 603);
                if (hsync_i !== exp_hs)
                begin
                    sync_errs++;
                    report_mismatch("hsync_o", int'(exp_hs), int'(hsync_i));
                end
                if (vsync_i !== exp_vs)
                begin
                    sync_errs++;
                    report_mismatch("vsync_o", int'(exp_vs), int'(vsync_i));
                end
                if (line < 16 && col < 576)
                begin
                    b   = (col < 192) ? 0 : ((col < 384) ? 1 : 2);
                    idx = (col / 4 % 64) * 2 + line / 8 % 2;  // column bits 7..2 over line bit 3
                    if (valid[b][idx])
                    begin
                        window_checks++;
                        exp_wh = shadow[b][idx][line / 2 % 4];
                        if (white_i !== exp_wh)
                        begin
                            window_errs++;
                            report_mismatch("white_o", int'(exp_wh), int'(white_i));
                        end
                    end
                end
                else
                begin
                    exp_wh = (col < 800 && line < 600) &&
                             (col == 0 || col == 799 || line == 0 || line == 599);
                    if (white_i !== exp_wh)
                    begin
                        border_errs++;
                        report_mismatch("white_o", int'(exp_wh), int'(white_i));
                    end
                end
            end
        end
        prev_vs = vsync_i;
    end

endmodule

// File: tb/lcd_vga_tb.sv
// lcd vga testbench
// fills the three lcd rams from a write table during vertical blanking
// and lets the checker compare the lcd window over the next frame
// a batch of ignored and overwriting writes is checked in the frame after
// sync, border and blanking are judged over both frames
`timescale 1ns/100ps

module lcd_vga_tb;

    localparam int N_FILL   = 384;                    // every nibble of all three banks
    localparam int N_WRITES = 400;
    localparam int WIN_PIX  = 16 * 576;               // lcd window pixels per frame

    typedef struct packed {
        logic [1:0] bank;
        logic [6:0] index;
        logic [3:0] data;
    } wr_entry_t;

    logic       clk_in;
    logic       reset_in;
    logic [9:0] addr_i;
    logic       we_i;
    logic [3:0] data_i;
    logic       hsync_o;
    logic       vsync_o;
    logic       white_o;

    wr_entry_t writes [0:N_WRITES-1];
    integer    seed;
    int        passed;
    int        failed;
    int        win_errs0;
    int        win_checks0;
    logic      ok;

    tb_clock u_clock (
        .clk_o   (clk_in),
        .reset_o (reset_in)
    );

    lcd_vga_top dut (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .addr_i   (addr_i),
        .we_i     (we_i),
        .data_i   (data_i),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .white_o  (white_o)
    );

    lcd_vga_checker u_check (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .addr_i   (addr_i),
        .we_i     (we_i),
        .data_i   (data_i),
        .hsync_i  (hsync_o),
        .vsync_i  (vsync_o),
        .white_i  (white_o)
    );

    task automatic build_table;
        int b;
        int i;
        int k;
        begin
            for (b = 0; b < 3; b++)
            begin
                for (i = 0; i < 128; i++)
                begin
                    writes[b*128+i].bank  = 2'(b + 1);
                    writes[b*128+i].index = 7'(i);
                    if (i % 4 == 3)
                        writes[b*128+i].data = 4'($random(seed));
                    else
                        writes[b*128+i].data = 4'((i % 16) ^ (i / 16) ^ (b + 1));
                end
            end
            for (k = 0; k < 8; k++)
            begin
                i = (k * 13 + 5) % 128;               // bank 0 write unlike slave 1 there
                writes[N_FILL+2*k] = {2'd0, 7'(i), ~writes[i].data};
                b = k % 3;
                i = (k * 29 + 3) % 128;               // second write to a filled nibble
                writes[N_FILL+2*k+1] = {2'(b + 1), 7'(i), ~writes[b*128+i].data};
            end
        end
    endtask

    task automatic apply_writes(input int first, input int last);
        int n;
        begin
            for (n = first; n <= last; n++)
            begin
                @(negedge clk_in);
                addr_i = {writes[n].bank, 1'b0, writes[n].index};
                data_i = writes[n].data;
                we_i   = 1'b1;
            end
            @(negedge clk_in);
            we_i = 1'b0;
        end
    endtask

    task automatic wait_vsync_rise(output logic found);
        int   n;
        logic prev;
        begin
            found = 1'b0;
            prev  = 1'b1;
            for (n = 0; n < 2 * 1056 * 628 && !found; n++)
            begin
                @(negedge clk_in);
                found = vsync_o && !prev;
                prev  = vsync_o;
            end
            if (found)
                @(posedge clk_in);                    // checker is done with that edge
            else
                $display("timeout: no rising vsync edge within two frames");
        end
    endtask

    task automatic end_test(input string name, input int errs, input logic complete);
        begin
            if (errs == 0 && complete)
            begin
                passed++;
                $display("test %s: ok", name);
            end
            else
            begin
                failed++;
                if (!complete)
                    $display("test %s: failed, fewer positions were checked than expected", name);
                else
                    $display("test %s: failed with %0d errors", name, errs);
            end
        end
    endtask

    initial
    begin : main
        int n;
        addr_i = '0;
        we_i   = 1'b0;
        data_i = '0;
        seed   = 52;
        passed = 0;
        failed = 0;
        ok     = 1'b0;
        build_table();
        for (n = 0; n < 20 && !ok; n++)
        begin
            @(posedge clk_in);
            ok = !reset_in;
        end
        if (!ok)
            $display("timeout: reset was never released");
        else
        begin
            repeat (2) @(posedge clk_in);             // pipeline fill
            // five reset cycles and one fill cycle
            end_test("reset", u_check.reset_errs, u_check.reset_checks >= 6);
            wait_vsync_rise(ok);
        end
        if (ok)
        begin
            apply_writes(0, N_FILL - 1);
            wait_vsync_rise(ok);
        end
        if (ok)
        begin
            end_test("lcd window", u_check.window_errs, u_check.window_checks == WIN_PIX);
            win_errs0   = u_check.window_errs;
            win_checks0 = u_check.window_checks;
            apply_writes(N_FILL, N_WRITES - 1);
            wait_vsync_rise(ok);
        end
        if (ok)
        begin
            end_test("ignored bank and overwrite", u_check.window_errs - win_errs0,
                     u_check.window_checks - win_checks0 == WIN_PIX);
            end_test("sync", u_check.sync_errs, u_check.frames_checked == 2);
            end_test("border and blanking", u_check.border_errs, u_check.frames_checked == 2);
        end
        $display("%0d passed, %0d failed, %0d run", passed, failed, passed + failed);
        if (ok && failed == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: project.f
design/lcd_vga_pkg.sv
design/scan_timing.sv
design/lcd_bank.sv
design/pixel_fetch.sv
design/pixel_render.sv
design/lcd_vga_top.sv
tb/tb_clock.sv
tb/lcd_vga_checker.sv
tb/lcd_vga_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the lcd vga mirror
TOP = lcd_vga_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	@grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
